/* portalPkg.sv */
package portalPkg;

  localparam int DataWidth = 32;
  localparam int IdWidth = 6;
  localparam int LenWidth = 4;       // Beats per burst is len plus one
  localparam int OffsetWidth = 5;
  localparam int RegionLsb = 5;
  localparam int RegionWidth = 7;    // All zero selects the control region
  localparam int PortalSelLsb = 12;
  localparam int NumPortals = 2;
  localparam int PortalSelWidth = (NumPortals > 1) ? $clog2(NumPortals) : 1;
  localparam int AddrWidth = 32;
  localparam int QueueDepth = 8;
  localparam int PortalIdBase = 5;
  localparam int NumTiles = 1;
  localparam logic [DataWidth-1:0] FillerWord = 32'h005A05A0;

  typedef logic [DataWidth-1:0] wordT;
  typedef logic [IdWidth-1:0] beatIdT;
  typedef logic [LenWidth-1:0] burstLenT;
  typedef logic [OffsetWidth-1:0] wordOffsetT;
  typedef logic [PortalSelWidth-1:0] portalIdxT;

  // Control word offsets inside a portal window
  typedef enum logic [OffsetWidth-1:0] {
    intStatus   = 5'h00,
    intEnable   = 5'h04,
    numTiles    = 5'h08,
    queueStatus = 5'h0C,
    portalId    = 5'h10,
    numPortals  = 5'h14
  } ctrlRegE;

  typedef enum logic [1:0] {
    idle,
    readBurst,
    writeBurst
  } schedStateE;

endpackage

/* portalBeatIf.sv */
`timescale 1ns/1ns

interface portalBeatIf;
  import portalPkg::*;

  logic beatValid;
  logic beatWrite;
  logic beatCtrl;      // Control region
  wordOffsetT beatOffset;
  wordT beatData;
  beatIdT beatId;
  logic beatLast;
  logic beatReady;
  wordT readData;      // Valid in the transfer cycle of a read beat

  modport issue (output beatValid, beatWrite, beatCtrl, beatOffset, beatData, beatId, beatLast,
                 input beatReady);

  modport serve (input beatValid, beatWrite, beatCtrl, beatOffset, beatData,
                 output beatReady, readData);

  modport observe (input beatValid, beatReady, beatWrite, beatLast, beatId, readData);

endinterface

/* beatScheduler.sv */
`timescale 1ns/1ns

module beatScheduler (
  input  logic CLK,
  input  logic RST_N,
  input  logic arValid,
  output logic arReady,
  input  logic [portalPkg::AddrWidth-1:0] arAddr,
  input  portalPkg::burstLenT arLen,
  input  portalPkg::beatIdT arId,
  input  logic awValid,
  output logic awReady,
  input  logic [portalPkg::AddrWidth-1:0] awAddr,
  input  portalPkg::burstLenT awLen,
  input  portalPkg::beatIdT awId,
  input  logic wValid,
  output logic wReady,
  input  portalPkg::wordT wData,
  input  logic readRoom,
  input  logic writeRoom,
  portalBeatIf.issue beat [portalPkg::NumPortals]
);
  import portalPkg::*;

  schedStateE state;
  wordOffsetT offset;
  burstLenT beatsLeft;
  beatIdT burstId;
  portalIdxT portalSel;
  logic ctrlRegion;

  logic [AddrWidth-1:0] startAddr;
  logic [NumPortals-1:0] readyVec;
  logic takeWrite;
  logic takeRead;
  logic lastBeat;
  logic issueValid;
  logic issueFire;

  assign awReady = (state == idle);
  assign arReady = (state == idle) && !awValid;  // Write address wins a tie
  assign takeWrite = (state == idle) && awValid;
  assign takeRead = (state == idle) && !awValid && arValid;
  assign startAddr = awValid ? awAddr : arAddr;

  assign lastBeat = (beatsLeft == '0);

  // Issue only when the collector can take the result
  always_comb begin
    case (state)
      readBurst:  issueValid = readRoom;
      writeBurst: issueValid = wValid && (!lastBeat || writeRoom);
      default:    issueValid = 1'b0;
    endcase
  end

  assign issueFire = issueValid && readyVec[portalSel];
  assign wReady = (state == writeBurst) && readyVec[portalSel] && (!lastBeat || writeRoom);

  for (genvar g = 0; g < NumPortals; g++) begin : gIssue
    assign beat[g].beatValid = issueValid && (portalSel == portalIdxT'(g));
    assign beat[g].beatWrite = (state == writeBurst);
    assign beat[g].beatCtrl = ctrlRegion;
    assign beat[g].beatOffset = offset;
    assign beat[g].beatData = wData;
    assign beat[g].beatId = burstId;
    assign beat[g].beatLast = lastBeat;
    assign readyVec[g] = beat[g].beatReady;
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (takeWrite) begin
            state <= writeBurst;
          end else if (takeRead) begin
            state <= readBurst;
          end
        end
        default: begin
          if (issueFire && lastBeat) begin
            state <= idle;  // Next burst may start one cycle later
          end
        end
      endcase
    end
  end

  // Burst context, loaded before any beat is issued
  always_ff @(posedge CLK) begin
    if (takeWrite || takeRead) begin
      offset <= startAddr[OffsetWidth-1:0];
      ctrlRegion <= (startAddr[RegionLsb +: RegionWidth] == '0);
      portalSel <= startAddr[PortalSelLsb +: PortalSelWidth];
      beatsLeft <= awValid ? awLen : arLen;
      burstId <= awValid ? awId : arId;
    end else if (issueFire) begin
      offset <= offset + wordOffsetT'(4);  // Wraps inside the window
      beatsLeft <= beatsLeft - 1'b1;
    end
  end

endmodule

/* mailboxPortal.sv */
`timescale 1ns/1ns

module mailboxPortal #(
  parameter int portalIndex = 0
) (
  input  logic CLK,
  input  logic RST_N,
  portalBeatIf.serve beat,
  output logic intRequest
);
  import portalPkg::*;

  wordT queueMem [QueueDepth];
  logic [$clog2(QueueDepth)-1:0] head;
  logic [$clog2(QueueDepth)-1:0] tail;
  logic [$clog2(QueueDepth+1)-1:0] count;
  logic irqEnable;

  logic queueEmpty;
  logic queueFull;
  logic enqueue;
  logic dequeue;
  logic beatFire;

  assign queueEmpty = (count == '0);
  assign queueFull = (int'(count) == QueueDepth);

  // User region only
  assign enqueue = !beat.beatCtrl && beat.beatWrite;
  assign dequeue = !beat.beatCtrl && !beat.beatWrite && (beat.beatOffset == '0);

  assign beat.beatReady = !((enqueue && queueFull) || (dequeue && queueEmpty));
  assign beatFire = beat.beatValid && beat.beatReady;

  assign intRequest = !queueEmpty && irqEnable;

  always_comb begin
    if (beat.beatCtrl) begin
      case (beat.beatOffset)
        intStatus:   beat.readData = wordT'(!queueEmpty);
        intEnable:   beat.readData = wordT'(irqEnable);
        numTiles:    beat.readData = wordT'(NumTiles);
        queueStatus: beat.readData = wordT'(count);
        portalId:    beat.readData = wordT'(PortalIdBase + portalIndex);
        numPortals:  beat.readData = wordT'(NumPortals);
        default:     beat.readData = FillerWord;
      endcase
    end else begin
      case (beat.beatOffset)
        5'h00:   beat.readData = queueMem[head];    // Head of mailbox
        5'h04:   beat.readData = wordT'(!queueFull);
        default: beat.readData = '0;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      irqEnable <= 1'b0;
    end else if (beatFire) begin
      if (enqueue) begin
        tail <= (int'(tail) == QueueDepth - 1) ? '0 : tail + 1'b1;
        count <= count + 1'b1;
      end
      if (dequeue) begin
        head <= (int'(head) == QueueDepth - 1) ? '0 : head + 1'b1;
        count <= count - 1'b1;
      end
      if (beat.beatCtrl && beat.beatWrite && (beat.beatOffset == intEnable)) begin
        irqEnable <= beat.beatData[0];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (beatFire && enqueue) begin
      queueMem[tail] <= beat.beatData;
    end
  end

endmodule

/* responseCollector.sv */
`timescale 1ns/1ns

module responseCollector (
  input  logic CLK,
  input  logic RST_N,
  input  logic rReady,
  input  logic bReady,
  portalBeatIf.observe beat [portalPkg::NumPortals],
  output logic rValid,
  output portalPkg::wordT rData,
  output portalPkg::beatIdT rId,
  output logic bValid,
  output portalPkg::beatIdT bId,
  output logic readRoom,
  output logic writeRoom
);
  import portalPkg::*;

  logic [NumPortals-1:0] readXfer;
  logic [NumPortals-1:0] doneXfer;
  wordT [NumPortals-1:0] dataVec;
  beatIdT [NumPortals-1:0] idVec;

  wordT pushData;
  beatIdT pushId;
  beatIdT doneId;
  logic push;
  logic pop;

  // Two-entry read data FIFO
  wordT fifoData [2];
  beatIdT fifoId [2];
  logic wrPtr;
  logic rdPtr;
  logic [1:0] fill;

  for (genvar g = 0; g < NumPortals; g++) begin : gObserve
    assign readXfer[g] = beat[g].beatValid && beat[g].beatReady && !beat[g].beatWrite;
    assign doneXfer[g] = beat[g].beatValid && beat[g].beatReady && beat[g].beatWrite
                         && beat[g].beatLast;
    assign dataVec[g] = beat[g].readData;
    assign idVec[g] = beat[g].beatId;
  end

  // At most one portal moves a beat per cycle
  always_comb begin
    pushData = '0;
    pushId = '0;
    doneId = '0;
    for (int i = 0; i < NumPortals; i++) begin
      if (readXfer[i]) begin
        pushData = dataVec[i];
        pushId = idVec[i];
      end
      if (doneXfer[i]) begin
        doneId = idVec[i];
      end
    end
  end

  assign push = |readXfer;
  assign pop = rValid && rReady;

  assign rValid = (fill != 2'd0);
  assign rData = fifoData[rdPtr];
  assign rId = fifoId[rdPtr];
  assign readRoom = (fill != 2'd2);
  assign writeRoom = !bValid;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      fill <= 2'd0;
      bValid <= 1'b0;
    end else begin
      if (push) wrPtr <= !wrPtr;
      if (pop) rdPtr <= !rdPtr;
      fill <= fill + {1'b0, push} - {1'b0, pop};
      if (|doneXfer) begin
        bValid <= 1'b1;
      end else if (bReady) begin
        bValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      fifoData[wrPtr] <= pushData;
      fifoId[wrPtr] <= pushId;
    end
    if (|doneXfer) bId <= doneId;  // Held until bReady
  end

endmodule

/* portalBridgeTop.sv */
`timescale 1ns/1ns

module portalBridgeTop (
  input  logic CLK,
  input  logic RST_N,
  input  logic arValid,
  output logic arReady,
  input  logic [portalPkg::AddrWidth-1:0] arAddr,
  input  portalPkg::burstLenT arLen,
  input  portalPkg::beatIdT arId,
  output logic rValid,
  input  logic rReady,
  output portalPkg::wordT rData,
  output portalPkg::beatIdT rId,
  input  logic awValid,
  output logic awReady,
  input  logic [portalPkg::AddrWidth-1:0] awAddr,
  input  portalPkg::burstLenT awLen,
  input  portalPkg::beatIdT awId,
  input  logic wValid,
  output logic wReady,
  input  portalPkg::wordT wData,
  output logic bValid,
  input  logic bReady,
  output portalPkg::beatIdT bId,
  output logic interrupt
);
  import portalPkg::*;

  logic readRoom;
  logic writeRoom;
  logic [NumPortals-1:0] portalIrq;

  portalBeatIf beatBus [NumPortals] ();

  beatScheduler scheduler (
    .CLK(CLK), .RST_N(RST_N),
    .arValid(arValid), .arReady(arReady), .arAddr(arAddr), .arLen(arLen), .arId(arId),
    .awValid(awValid), .awReady(awReady), .awAddr(awAddr), .awLen(awLen), .awId(awId),
    .wValid(wValid), .wReady(wReady), .wData(wData),
    .readRoom(readRoom), .writeRoom(writeRoom),
    .beat(beatBus)
  );

  for (genvar g = 0; g < NumPortals; g++) begin : gPortal
    mailboxPortal #(.portalIndex(g)) portal (
      .CLK(CLK), .RST_N(RST_N),
      .beat(beatBus[g]),
      .intRequest(portalIrq[g])
    );
  end

  responseCollector collector (
    .CLK(CLK), .RST_N(RST_N),
    .rReady(rReady), .bReady(bReady),
    .beat(beatBus),
    .rValid(rValid), .rData(rData), .rId(rId),
    .bValid(bValid), .bId(bId),
    .readRoom(readRoom), .writeRoom(writeRoom)
  );

  assign interrupt = |portalIrq;

endmodule

/* portalBridgeTb.sv */
`timescale 1ns/1ns

module portalBridgeTb;
  import portalPkg::*;

  localparam int dataLcg = 0;
  localparam int dataOne = 1;
  localparam int dataZero = 2;

  typedef struct {
    string name;
    bit write;
    int portal;
    bit ctrl;       // Control region, else user region
    int offset;
    int len;
    int id;
    int kind;       // Source of write data
    int stall;      // Cycles with rReady and bReady low
  } testT;

  logic CLK;
  logic RST_N;
  logic arValid, arReady, rValid, rReady, awValid, awReady, wValid, wReady, bValid, bReady;
  logic interrupt;
  logic [AddrWidth-1:0] arAddr, awAddr;
  burstLenT arLen, awLen;
  beatIdT arId, awId, rId, bId;
  wordT rData, wData;

  testT tests[$];
  wordT mbox[NumPortals][$];
  bit enBit[NumPortals];
  int unsigned lcgState = 35;
  int errors = 0;
  int checks = 0;
  int cycleCount = 0;
  int cycleLimit = 0;

  portalBridgeTop i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) cycleCount <= cycleCount + 1;

  initial begin
    wait (cycleLimit > 0);
    wait (cycleCount >= cycleLimit);
    $display("Timeout after %0d cycles, the DUT stopped answering", cycleCount);
    $display("Done: errors found");
    $finish;
  end

  function automatic wordT nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return wordT'(lcgState);
  endfunction

  // Expected read word, pops the mailbox model on offset 0
  function automatic wordT modelRead(int p, bit ctrl, int off);
    if (ctrl) begin
      case (off)
        'h00: return wordT'(mbox[p].size() != 0);
        'h04: return wordT'(enBit[p]);
        'h08: return wordT'(NumTiles);
        'h0C: return wordT'(mbox[p].size());
        'h10: return wordT'(PortalIdBase + p);
        'h14: return wordT'(NumPortals);
        default: return FillerWord;
      endcase
    end
    if (off == 0) return mbox[p].pop_front();
    if (off == 4) return wordT'(mbox[p].size() < QueueDepth);
    return '0;
  endfunction

  function automatic bit modelIrq();
    bit irq;
    irq = 1'b0;
    for (int p = 0; p < NumPortals; p++) irq |= (mbox[p].size() != 0) && enBit[p];
    return irq;
  endfunction

  task automatic checkWord(string name, wordT expected, wordT actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkId(string name, beatIdT expected, beatIdT actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s id: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic checkFlag(string name, bit expected, logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s interrupt: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic runTest(testT t);
    wordT words[$];
    wordT data;
    logic [AddrWidth-1:0] addr;
    int off;
    int idx;
    int cyc;
    int errBefore;
    bit done;
    errBefore = errors;
    addr = (t.portal << PortalSelLsb) | ((t.ctrl ? 0 : 1) << RegionLsb) | t.offset;
    for (int i = 0; i <= t.len; i++) begin
      off = (t.offset + 4 * i) % (1 << OffsetWidth);  // Offset wraps in the window
      if (t.write) begin
        data = (t.kind == dataOne) ? 1 : (t.kind == dataZero) ? 0 : nextRand();
        words.push_back(data);
        if (t.ctrl && off == 4) enBit[t.portal] = data[0];
        else if (!t.ctrl) mbox[t.portal].push_back(data);
      end else begin
        words.push_back(modelRead(t.portal, t.ctrl, off));
      end
    end
    awValid = t.write;
    awAddr = addr;
    awLen = burstLenT'(t.len);
    awId = beatIdT'(t.id);
    arValid = !t.write;
    arAddr = addr;
    arLen = burstLenT'(t.len);
    arId = beatIdT'(t.id);
    do @(posedge CLK); while (!(t.write ? awReady : arReady));
    #1;
    awValid = 1'b0;
    arValid = 1'b0;
    wValid = t.write;
    wData = words[0];
    rReady = (t.stall == 0);
    bReady = (t.stall == 0);
    idx = 0;
    cyc = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge CLK);
      if (t.write) begin
        if (wValid && wReady) idx++;
        if (bValid && bReady) begin
          checkId(t.name, beatIdT'(t.id), bId);
          if (idx != t.len + 1) begin
            errors++;
            $display("%s: write response came after %0d of %0d beats", t.name, idx, t.len + 1);
          end
          done = 1'b1;
        end
      end else if (rValid && rReady) begin
        checkWord(t.name, words[idx], rData);
        checkId(t.name, beatIdT'(t.id), rId);
        idx++;
        done = (idx > t.len);
      end
      cyc++;
      #1;
      wValid = t.write && (idx <= t.len) && !done;
      if (idx <= t.len) wData = words[idx];
      rReady = (cyc >= t.stall);
      bReady = (cyc >= t.stall);
    end
    // Nothing may be left over once the scheduler is idle again
    rReady = 1'b0;
    bReady = 1'b0;
    do @(posedge CLK); while (!arReady);
    if (rValid || bValid) begin
      errors++;
      $display("%s: extra response left after the last beat", t.name);
    end
    #1;
    checkFlag(t.name, modelIrq(), interrupt);
    $display("%-10s %0d beats, %s", t.name, t.len + 1, (errors == errBefore) ? "ok" : "mismatch");
  endtask

  initial begin
    int beatsTotal;
    RST_N = 1'b0;
    arValid = 1'b0;
    arAddr = '0;
    arLen = '0;
    arId = '0;
    rReady = 1'b1;
    awValid = 1'b0;
    awAddr = '0;
    awLen = '0;
    awId = '0;
    wValid = 1'b0;
    wData = '0;
    bReady = 1'b1;
    // name, write, portal, ctrl, offset, len, id, kind, stall
    tests.push_back('{"ctrlIds0", 0, 0, 1, 'h08, 3, 1, dataLcg, 0});
    tests.push_back('{"ctrlFill1", 0, 1, 1, 'h10, 3, 2, dataLcg, 0});
    tests.push_back('{"wrUser0", 1, 0, 0, 'h00, 1, 3, dataLcg, 0});
    tests.push_back('{"wrUser1", 1, 1, 0, 'h00, 1, 4, dataLcg, 0});
    tests.push_back('{"qStat0", 0, 0, 1, 'h0C, 0, 5, dataLcg, 0});
    tests.push_back('{"qStat1", 0, 1, 1, 'h0C, 0, 6, dataLcg, 0});
    tests.push_back('{"rdUser0", 0, 0, 0, 'h00, 0, 7, dataLcg, 0});
    tests.push_back('{"rdUser1", 0, 1, 0, 'h00, 1, 8, dataLcg, 0});
    tests.push_back('{"fillUser1", 1, 1, 0, 'h00, 6, 9, dataLcg, 0});
    tests.push_back('{"fullFlag1", 0, 1, 0, 'h04, 0, 10, dataLcg, 0});
    tests.push_back('{"irqOn0", 1, 0, 1, 'h04, 0, 11, dataOne, 0});
    tests.push_back('{"irqStat0", 0, 0, 1, 'h00, 1, 12, dataLcg, 0});
    tests.push_back('{"drain0", 0, 0, 0, 'h00, 0, 13, dataLcg, 0});
    tests.push_back('{"irqOn1", 1, 1, 1, 'h04, 0, 14, dataOne, 0});
    tests.push_back('{"irqOff1", 1, 1, 1, 'h04, 0, 15, dataZero, 0});
    tests.push_back('{"rdStall1", 0, 1, 0, 'h00, 8, 16, dataLcg, 6});
    tests.push_back('{"wrStall0", 1, 0, 0, 'h08, 3, 17, dataLcg, 5});
    tests.push_back('{"rdStall0", 0, 0, 0, 'h00, 8, 18, dataLcg, 4});
    beatsTotal = 0;
    foreach (tests[i]) beatsTotal += tests[i].len + 1;
    cycleLimit = 40 * beatsTotal + 200;
    repeat (16) @(posedge CLK);
    #1;
    RST_N = 1'b1;
    foreach (tests[i]) runTest(tests[i]);
    $display("Tests: %0d, checks: %0d, errors: %0d", tests.size(), checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* build.f */
portalPkg.sv
portalBeatIf.sv
beatScheduler.sv
mailboxPortal.sv
responseCollector.sv
portalBridgeTop.sv
portalBridgeTb.sv

/* runSim.sh */
#!/bin/bash
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -Wno-fatal -f build.f --top-module portalBridgeTb -o simv \
  && out=$(./obj_dir/simv) || { echo "$out"; echo "Build or run failed"; exit 1; }
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
